//--- include/boot_defs.svh
`ifndef BOOT_DEFS_SVH
`define BOOT_DEFS_SVH

// Word address into the boot ROM, wb_adr_i[6:2]
`define BOOT_ADDR_WIDTH 5

// Interleaved banks, selected by the low address bits
`define BOOT_NUM_BANKS 4
`define BOOT_BANK_BITS 2

// Data shown before the first read, the no-op instruction
`define BOOT_RESET_WORD 32'h1500_0000

`endif

//--- logic/wb_pkg.sv
`default_nettype none

package wb_pkg;

   // Cycle type identifier, Wishbone B3 registered feedback
   typedef enum logic [2:0] {
      WB_CTI_CLASSIC = 3'b000,
      WB_CTI_CONST   = 3'b001,
      WB_CTI_INCR    = 3'b010,
      WB_CTI_EOB     = 3'b111
   } wb_cti_e;

   // Burst type extension, only meaningful for incrementing bursts
   typedef enum logic [1:0] {
      WB_BTE_LINEAR = 2'b00,
      WB_BTE_WRAP4  = 2'b01,
      WB_BTE_WRAP8  = 2'b10,
      WB_BTE_WRAP16 = 2'b11
   } wb_bte_e;

endpackage

`default_nettype wire

//--- logic/boot_pkg.sv
`default_nettype none

`include "boot_defs.svh"

package boot_pkg;

   // One ROM word address, seen as a linear index by the address
   // generator and as row plus bank by the bank array
   typedef union packed {
      logic [`BOOT_ADDR_WIDTH-1:0] index;
      struct packed {
         logic [`BOOT_ADDR_WIDTH-`BOOT_BANK_BITS-1:0] row;
         logic [`BOOT_BANK_BITS-1:0]                  bank;
      } loc;
   } rom_addr_u;

   // Reset program, every word past the end reads as zero
   localparam logic [31:0] BOOT_PROGRAM [5] = '{
      32'h1800_0000,      // l.movhi r0,0
      32'hA820_0000,      // l.ori r1,r0,0x0
      32'hA8C0_0100,      // l.ori r6,r0,0x100
      32'h4400_3000,      // l.jr r6
      `BOOT_RESET_WORD    // l.nop in the delay slot
   };

endpackage

`default_nettype wire

//--- logic/wb_burst_addr.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module wb_burst_addr import wb_pkg::*, boot_pkg::*; (
   input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic [`BOOT_ADDR_WIDTH+1:2]  wb_adr_i,
   input  logic                         wb_stb_i,
   input  logic                         wb_cyc_i,
   input  wb_cti_e                      wb_cti_i,
   input  wb_bte_e                      wb_bte_i,
   output rom_addr_u                    rd_addr_o,
   output logic                         rd_en_o,
   output logic                         last_o
);

   logic                        req;
   logic                        cti_burst;
   logic                        new_access;
   logic                        burst_beat;
   logic                        issue;
   logic                        do_inc;
   logic                        burst_q;
   logic [2:0]                  cls_pend_q;
   logic [`BOOT_ADDR_WIDTH-1:0] wrap_mask;
   logic [`BOOT_ADDR_WIDTH-1:0] inc_idx;

   assign req       = wb_cyc_i & wb_stb_i;
   assign cti_burst = (wb_cti_i == WB_CTI_CONST) || (wb_cti_i == WB_CTI_INCR);

   // A classic read blocks new accesses until its ack has come and gone
   assign new_access = req & ~rd_en_o & ~burst_q & (cls_pend_q == '0);
   assign burst_beat = req & burst_q;
   assign issue      = new_access | burst_beat;
   assign do_inc     = burst_beat & (wb_cti_i == WB_CTI_INCR);

   // Bits that are allowed to carry during an incrementing burst
   always_comb begin
      case (wb_bte_i)
         WB_BTE_WRAP4:  wrap_mask = {{(`BOOT_ADDR_WIDTH-2){1'b0}}, 2'b11};
         WB_BTE_WRAP8:  wrap_mask = {{(`BOOT_ADDR_WIDTH-3){1'b0}}, 3'b111};
         WB_BTE_WRAP16: wrap_mask = {{(`BOOT_ADDR_WIDTH-4){1'b0}}, 4'b1111};
         default:       wrap_mask = '1;
      endcase
   end

   assign inc_idx = (rd_addr_o.index & ~wrap_mask) |
                    ((rd_addr_o.index + 1'b1) & wrap_mask);

   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         rd_en_o    <= 1'b0;
         last_o     <= 1'b0;
         burst_q    <= 1'b0;
         cls_pend_q <= '0;
      end else begin
         rd_en_o    <= issue;
         last_o     <= issue & ~cti_burst;
         cls_pend_q <= {cls_pend_q[1:0], new_access & ~cti_burst};
         // Strobe low or an end-of-burst read ends the burst
         if (!req) begin
            burst_q <= 1'b0;
         end else if (issue) begin
            burst_q <= cti_burst;
         end
      end
   end

   // Address register is only meaningful while rd_en_o is high
   always_ff @(posedge wb_clk) begin
      if (issue) begin
         if (do_inc) begin
            rd_addr_o.index <= inc_idx;
         end else begin
            rd_addr_o.index <= wb_adr_i;
         end
      end
   end

   // Wrapping never leaves the aligned block of the burst
   a_wrap_in_block: assert property (
      @(posedge wb_clk) disable iff (wb_rst)
      do_inc && (wb_bte_i != WB_BTE_LINEAR) |=>
         ((rd_addr_o.index ^ $past(rd_addr_o.index)) >>
          (int'($past(wb_bte_i)) + 1)) == '0
   );

endmodule

`default_nettype wire

//--- logic/boot_rom_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module boot_rom_bank import boot_pkg::*; (
   input  logic                        wb_clk,
   input  logic                        wb_rst,
   input  logic [`BOOT_BANK_BITS-1:0]  bank_id_i,
   input  rom_addr_u                   rd_addr_i,
   input  logic                        rd_en_i,
   output logic [31:0]                 bank_dat_o
);

   logic                        bank_sel;
   logic [`BOOT_ADDR_WIDTH-1:0] word_idx;
   logic [31:0]                 rom_word;

   // This bank holds every word whose low bits equal its id
   assign bank_sel = rd_en_i & (rd_addr_i.loc.bank == bank_id_i);
   assign word_idx = {rd_addr_i.loc.row, bank_id_i};

   // Table lookup, zero beyond the program
   always_comb begin
      rom_word = '0;
      for (int i = 0; i < $size(BOOT_PROGRAM); i++) begin
         if (word_idx == i) begin
            rom_word = BOOT_PROGRAM[i];
         end
      end
   end

   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         bank_dat_o <= '0;
      end else if (bank_sel) begin
         bank_dat_o <= rom_word;
      end
   end

endmodule

`default_nettype wire

//--- logic/boot_rd_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module boot_rd_mux import boot_pkg::*; (
   input  logic         wb_clk,
   input  logic         wb_rst,
   input  logic         wb_cyc_i,
   input  logic         wb_stb_i,
   input  rom_addr_u    rd_addr_i,
   input  logic         rd_en_i,
   input  logic         last_i,
   input  logic [31:0]  bank_dat_i [`BOOT_NUM_BANKS],
   output logic [31:0]  wb_dat_o,
   output logic         wb_ack_o
);

   logic                       req;
   logic                       rd_en_d;
   logic                       last_d;
   logic                       active_q;
   logic                       ack_q;
   logic [`BOOT_BANK_BITS-1:0] bank_d;

   assign req = wb_cyc_i & wb_stb_i;

   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         rd_en_d  <= 1'b0;
         last_d   <= 1'b0;
         active_q <= 1'b0;
         ack_q    <= 1'b0;
         wb_dat_o <= `BOOT_RESET_WORD;
      end else begin
         rd_en_d <= rd_en_i;
         last_d  <= last_i;
         ack_q   <= rd_en_d & active_q & req;
         if (rd_en_d) begin
            wb_dat_o <= bank_dat_i[bank_d];
         end
         // Reads still in flight when the master lets go are dropped
         if (!req) begin
            active_q <= 1'b0;
         end else if (rd_en_i) begin
            active_q <= 1'b1;
         end else if (rd_en_d && last_d) begin
            active_q <= 1'b0;
         end
      end
   end

   // Bank field lines up with the registered bank output
   always_ff @(posedge wb_clk) begin
      bank_d <= rd_addr_i.loc.bank;
   end

   assign wb_ack_o = ack_q & req;

   // An ack only answers a read whose cycle the master held from issue onwards
   a_ack_in_cycle: assert property (
      @(posedge wb_clk) disable iff (wb_rst)
      wb_ack_o |-> $past(req, 1) && $past(req, 2) && $past(req, 3)
   );

endmodule

`default_nettype wire

//--- logic/wb_boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module wb_boot_rom import wb_pkg::*, boot_pkg::*; (
   input  logic                         wb_clk,
   input  logic                         wb_rst,
   input  logic [`BOOT_ADDR_WIDTH+1:2]  wb_adr_i,
   input  logic                         wb_stb_i,
   input  logic                         wb_cyc_i,
   input  wb_cti_e                      wb_cti_i,
   input  wb_bte_e                      wb_bte_i,
   output logic [31:0]                  wb_dat_o,
   output logic                         wb_ack_o
);

   rom_addr_u   rd_addr;
   logic        rd_en;
   logic        rd_last;
   logic [31:0] bank_dat [`BOOT_NUM_BANKS];

   wb_burst_addr u_addr (
      .wb_clk    (wb_clk),
      .wb_rst    (wb_rst),
      .wb_adr_i  (wb_adr_i),
      .wb_stb_i  (wb_stb_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_cti_i  (wb_cti_i),
      .wb_bte_i  (wb_bte_i),
      .rd_addr_o (rd_addr),
      .rd_en_o   (rd_en),
      .last_o    (rd_last)
   );

   for (genvar g = 0; g < `BOOT_NUM_BANKS; g++) begin : g_bank
      localparam logic [`BOOT_BANK_BITS-1:0] BANK_ID = g;

      boot_rom_bank u_bank (
         .wb_clk     (wb_clk),
         .wb_rst     (wb_rst),
         .bank_id_i  (BANK_ID),
         .rd_addr_i  (rd_addr),
         .rd_en_i    (rd_en),
         .bank_dat_o (bank_dat[g])
      );
   end

   boot_rd_mux u_mux (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .rd_addr_i  (rd_addr),
      .rd_en_i    (rd_en),
      .last_i     (rd_last),
      .bank_dat_i (bank_dat),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o)
   );

endmodule

`default_nettype wire

//--- dv/tb_wb_boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module tb_wb_boot_rom import wb_pkg::*, boot_pkg::*;;

   localparam int ACK_TIMEOUT = 16;

   logic                         wb_clk;
   logic                         wb_rst;
   logic [`BOOT_ADDR_WIDTH+1:2]  wb_adr_i;
   logic                         wb_stb_i;
   logic                         wb_cyc_i;
   wb_cti_e                      wb_cti_i;
   wb_bte_e                      wb_bte_i;
   logic [31:0]                  wb_dat_o;
   logic                         wb_ack_o;

   int                           len;
   logic [`BOOT_ADDR_WIDTH-1:0]  addr;

   wb_boot_rom uut (
      .wb_clk   (wb_clk),
      .wb_rst   (wb_rst),
      .wb_adr_i (wb_adr_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_cti_i (wb_cti_i),
      .wb_bte_i (wb_bte_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;
   end

   // Reference model with the program words first and zero everywhere else
   function automatic logic [31:0] expected_word(input logic [`BOOT_ADDR_WIDTH-1:0] idx);
      if (int'(idx) < $size(BOOT_PROGRAM)) begin
         return BOOT_PROGRAM[idx];
      end
      return 32'h0;
   endfunction

   // Next beat of an incrementing burst stays inside its aligned block
   function automatic logic [`BOOT_ADDR_WIDTH-1:0] next_index(
      input logic [`BOOT_ADDR_WIDTH-1:0] idx, input wb_bte_e bte);
      int size;
      int base;
      case (bte)
         WB_BTE_WRAP4:  size = 4;
         WB_BTE_WRAP8:  size = 8;
         WB_BTE_WRAP16: size = 16;
         default:       size = 32;
      endcase
      base = int'(idx) - (int'(idx) % size);
      return base + ((int'(idx) - base + 1) % size);
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("[ERROR] %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
         $display("Test FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out at %0d ns while waiting for %s", $time, what);
      $display("Test FAILED");
      $fatal(1, "simulation stopped after timeout");
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge wb_clk);
         wb_cyc_i = 1'b0;
         wb_stb_i = 1'b0;
         wb_cti_i = WB_CTI_CLASSIC;
      end
   endtask

   task automatic classic_read(input logic [`BOOT_ADDR_WIDTH-1:0] a);
      int   waited;
      logic got;
      @(negedge wb_clk);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_adr_i = a;
      wb_cti_i = WB_CTI_CLASSIC;
      wb_bte_i = wb_bte_e'($urandom_range(3, 0));
      waited = 0;
      got = 1'b0;
      while (!got) begin
         @(negedge wb_clk);
         if (wb_ack_o) begin
            got = 1'b1;
         end else begin
            waited++;
            if (waited > ACK_TIMEOUT) report_timeout("a classic read acknowledge");
         end
      end
      check_value("classic read data", expected_word(a), wb_dat_o);
      // Strobe still high here, so a second ack would show up now
      @(negedge wb_clk);
      check_value("classic ack width", 32'h0, {31'h0, wb_ack_o});
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   // Burst of blen beats where the master lets go of cyc after stop_at acks
   task automatic run_burst(input wb_cti_e kind, input wb_bte_e bte,
                            input logic [`BOOT_ADDR_WIDTH-1:0] start,
                            input int blen, input int stop_at);
      logic [`BOOT_ADDR_WIDTH-1:0] beat_adr [$];
      int                          n;
      int                          acks;
      int                          waited;
      beat_adr = {};
      beat_adr.push_back(start);
      for (int i = 1; i < blen; i++) begin
         if (kind == WB_CTI_INCR) begin
            beat_adr.push_back(next_index(beat_adr[i-1], bte));
         end else begin
            beat_adr.push_back(`BOOT_ADDR_WIDTH'($urandom_range(31, 0)));
         end
      end
      idle_cycles(4);
      @(negedge wb_clk);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_adr_i = start;
      wb_bte_i = bte;
      wb_cti_i = (blen == 1) ? WB_CTI_EOB : kind;
      n = 1;
      acks = 0;
      waited = 0;
      while (acks < stop_at) begin
         @(negedge wb_clk);
         // Once data flows the slave answers every cycle
         if (acks > 0) check_value("burst ack held", 32'h1, {31'h0, wb_ack_o});
         if (wb_ack_o) begin
            check_value("burst data", expected_word(beat_adr[acks]), wb_dat_o);
            acks++;
         end else begin
            waited++;
            if (waited > ACK_TIMEOUT) report_timeout("the first burst acknowledge");
         end
         if (acks < stop_at && n < blen) begin
            wb_adr_i = beat_adr[n];
            wb_cti_i = (n == blen - 1) ? WB_CTI_EOB : kind;
            n++;
         end
      end
      // A complete burst gets no ack beyond its last beat
      if (stop_at == blen) begin
         @(negedge wb_clk);
         check_value("ack after end of burst", 32'h0, {31'h0, wb_ack_o});
      end
      wb_cyc_i = 1'b0;
      repeat (6) begin
         @(negedge wb_clk);
         check_value("ack after cycle end", 32'h0, {31'h0, wb_ack_o});
      end
      wb_stb_i = 1'b0;
   endtask

   initial begin
      void'($urandom(69596));
      wb_rst = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_adr_i = '0;
      wb_cti_i = WB_CTI_CLASSIC;
      wb_bte_i = WB_BTE_LINEAR;
      repeat (4) @(negedge wb_clk);
      wb_rst = 1'b0;
      @(negedge wb_clk);
      check_value("ack after reset", 32'h0, {31'h0, wb_ack_o});
      check_value("data after reset", `BOOT_RESET_WORD, wb_dat_o);

      // Half of the classic reads land in or near the program
      repeat (24) begin
         idle_cycles($urandom_range(2, 0));
         if ($urandom_range(1, 0) == 1) begin
            addr = `BOOT_ADDR_WIDTH'($urandom_range(7, 0));
         end else begin
            addr = `BOOT_ADDR_WIDTH'($urandom_range(31, 0));
         end
         classic_read(addr);
      end

      repeat (10) begin
         len = $urandom_range(40, 1);
         run_burst(WB_CTI_INCR, WB_BTE_LINEAR, `BOOT_ADDR_WIDTH'($urandom_range(31, 0)),
                   len, len);
      end

      repeat (15) begin
         len = $urandom_range(20, 1);
         run_burst(WB_CTI_INCR, wb_bte_e'($urandom_range(3, 1)),
                   `BOOT_ADDR_WIDTH'($urandom_range(31, 0)), len, len);
      end

      repeat (8) begin
         len = $urandom_range(12, 1);
         run_burst(WB_CTI_CONST, wb_bte_e'($urandom_range(3, 0)),
                   `BOOT_ADDR_WIDTH'($urandom_range(31, 0)), len, len);
      end

      // Master abandons the burst and a plain read must still work afterwards
      repeat (6) begin
         len = $urandom_range(12, 3);
         run_burst(WB_CTI_INCR, wb_bte_e'($urandom_range(3, 0)),
                   `BOOT_ADDR_WIDTH'($urandom_range(31, 0)), len, $urandom_range(len - 1, 1));
         classic_read(`BOOT_ADDR_WIDTH'($urandom_range(7, 0)));
      end

      idle_cycles(2);
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
logic/wb_pkg.sv
logic/boot_pkg.sv
logic/wb_burst_addr.sv
logic/boot_rom_bank.sv
logic/boot_rd_mux.sv
logic/wb_boot_rom.sv
dv/tb_wb_boot_rom.sv

//--- Bender.yml
package:
  name: wb_boot_rom

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/wb_pkg.sv
      - logic/boot_pkg.sv
      - logic/wb_burst_addr.sv
      - logic/boot_rom_bank.sv
      - logic/boot_rd_mux.sv
      - logic/wb_boot_rom.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_wb_boot_rom.sv
